// File: bench/link_test_tb.sv
/*
 * Link self-test testbench
 * Trains the link, gates it at random, injects a bit error and resets mid-run
 */
`timescale 1ns/1ps

module link_test_tb;
   import link_pkg::*;

   localparam int LANE_DELAY  = 3;
   localparam int ALIGN_WORDS = 5;
   localparam int TIMEOUT     = 200;
   localparam int GATE_CYCLES = 300;

   // Valid rises on the first enabled edge, the first word is taken on the second,
   // then one encoder cycle and the channel before the decoder sees it
   localparam int MIN_UP_CYCLES = 2 + 1 + LANE_DELAY + ALIGN_WORDS - 1;

   logic             FCLK;
   logic             ARSTn;
   logic             link_enable;
   logic             inject_error;
   link_state_t      link_state;
   ecode_t           ecode;
   logic [LED_W-1:0] led;

   integer seed;
   integer rnd;
   int     en_cycles;
   int     drop_at;
   int     waited;
   logic   gating;
   logic   latched;

   link_test_top #(
      .LANE_DELAY (LANE_DELAY),
      .ALIGN_WORDS(ALIGN_WORDS)
   ) uut (
      .FCLK        (FCLK),
      .ARSTn       (ARSTn),
      .link_enable (link_enable),
      .inject_error(inject_error),
      .link_state  (link_state),
      .ecode       (ecode),
      .led         (led)
   );

   always #5 FCLK = ~FCLK;

   task automatic stop_on_error(input string msg);
      $display("%s", msg);
      $display("TESTBENCH FAILED");
      $fatal(1, "stopping at first error");
   endtask

   // Enabled cycles since reset, bounds how early the link may come up
   always @(posedge FCLK or negedge ARSTn) begin
      if (!ARSTn) begin
         en_cycles <= 0;
      end else if (link_enable) begin
         en_cycles <= en_cycles + 1;
      end
   end

   a_no_early_up: assert property (
      @(posedge FCLK) disable iff (!ARSTn)
      link_state == LINK_UP |-> en_cycles >= MIN_UP_CYCLES
   ) else stop_on_error($sformatf("Link reached LINK_UP after only %0d enabled cycles",
                                  en_cycles));

   a_clean_while_gated: assert property (
      @(posedge FCLK) disable iff (!ARSTn)
      gating |-> led == 3'b111 && link_state == LINK_UP
   ) else stop_on_error($sformatf("Error: led = 0x%h link_state = 0x%h, expected 0x7 and 0x%h",
                                  led, link_state, LINK_UP));

   a_error_latched: assert property (
      @(posedge FCLK) disable iff (!ARSTn)
      latched |-> ecode == ECODE_CHECKSUM && led[2:1] == 2'b00
   ) else stop_on_error($sformatf("Error: ecode = 0x%h led = 0x%h, expected 0x1 and 0x0/0x1",
                                  ecode, led));

   task automatic check_reset_state();
      assert (link_state == LINK_DOWN)
         else stop_on_error($sformatf("Error: link_state = 0x%h, expected 0x%h",
                                      link_state, LINK_DOWN));
      assert (ecode == ECODE_NONE)
         else stop_on_error($sformatf("Error: ecode = 0x%h, expected 0x%h", ecode, ECODE_NONE));
      assert (led == 3'b110)
         else stop_on_error($sformatf("Error: led = 0x%h, expected 0x6", led));
   endtask

   // Called on a falling edge, leaves the link enabled
   task automatic apply_reset();
      ARSTn = 1'b0;
      repeat (2) begin
         @(negedge FCLK);
         check_reset_state();
      end
      ARSTn       = 1'b1;
      link_enable = 1'b1;
      @(negedge FCLK);
      check_reset_state();
   endtask

   task automatic wait_link_up();
      int cycles;
      cycles = 0;
      while (link_state != LINK_UP) begin
         @(negedge FCLK);
         cycles++;
         if (cycles > TIMEOUT) begin
            stop_on_error("Timeout: link never reached LINK_UP");
         end
      end
      assert (led[0] == 1'b1)
         else stop_on_error($sformatf("Error: led = 0x%h, expected bit 0 set", led));
   endtask

   initial begin
      seed         = 52336;
      FCLK         = 1'b0;
      ARSTn        = 1'b0;
      link_enable  = 1'b0;
      inject_error = 1'b0;
      gating       = 1'b0;
      latched      = 1'b0;

      apply_reset();
      wait_link_up();

      // Random link gating with a drain of the words still in flight
      gating = 1'b1;
      for (int i = 0; i < GATE_CYCLES; i++) begin
         @(negedge FCLK);
         rnd         = $random(seed);
         link_enable = rnd[0];
      end
      @(negedge FCLK);
      link_enable = 1'b1;
      repeat (LANE_DELAY + 4) @(negedge FCLK);
      gating = 1'b0;

      // Single bit error on one word
      inject_error = 1'b1;
      @(negedge FCLK);
      inject_error = 1'b0;
      waited = 0;
      while (ecode == ECODE_NONE) begin
         @(negedge FCLK);
         waited++;
         if (waited > TIMEOUT) begin
            stop_on_error("Timeout: injected error never set the error code");
         end
      end
      drop_at = en_cycles;
      assert (link_state == LINK_TRAINING)
         else stop_on_error($sformatf("Error: link_state = 0x%h, expected 0x%h",
                                      link_state, LINK_TRAINING));
      assert (ecode == ECODE_CHECKSUM)
         else stop_on_error($sformatf("Error: ecode = 0x%h, expected 0x%h",
                                      ecode, ECODE_CHECKSUM));
      waited = 0;
      while (led[2] != 1'b0) begin
         @(negedge FCLK);
         waited++;
         if (waited > TIMEOUT) begin
            stop_on_error("Timeout: checker never flagged the corrupt word");
         end
      end
      latched = 1'b1;
      wait_link_up();
      assert (en_cycles - drop_at == ALIGN_WORDS)
         else stop_on_error($sformatf("Error: recovery cycles = 0x%h, expected 0x%h",
                                      en_cycles - drop_at, ALIGN_WORDS));
      repeat (20) @(negedge FCLK);

      // Mid-run reset clears the latched errors
      latched = 1'b0;
      apply_reset();
      wait_link_up();
      gating = 1'b1;
      repeat (20) @(negedge FCLK);
      gating = 1'b0;

      $display("TESTBENCH PASSED");
      $finish;
   end

endmodule

// File: run_sim.sh
#!/usr/bin/env bash
# Compile the link self-test with Verilator and run it.
# The run passes only if the testbench prints its pass message.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
   -f src.f \
   --top-module link_test_tb \
   -o link_test_sim \
   || { echo "Verilator build failed"; exit 1; }

./obj_dir/link_test_sim | tee /dev/stderr | grep "TESTBENCH PASSED" > /dev/null \
   && { echo "Simulation result: pass"; exit 0; } \
   || { echo "Simulation result: fail"; exit 1; }

// File: src.f
verilog/link_pkg.sv
verilog/lane_if.sv
verilog/pattern_gen.sv
verilog/lane_encoder.sv
verilog/lane_channel.sv
verilog/lane_decoder.sv
verilog/traffic_checker.sv
verilog/link_test_top.sv
bench/link_test_tb.sv

// File: verilog/lane_channel.sv
/*
 * Lane channel model
 * Gated fixed-delay shift pipeline with link enable and bit error injection
 */
`timescale 1ns/1ps

module lane_channel #(
   parameter int LANE_DELAY = 4
) (
   input  logic      FCLK,
   input  logic      ARSTn,
   input  logic      link_enable,
   input  logic      inject_error,
   lane_if.receiver  rx,
   lane_if.sender    tx
);
   import link_pkg::*;

   word_t                 data_q [LANE_DELAY];
   check_t                check_q[LANE_DELAY];
   logic [LANE_DELAY-1:0] valid_q;
   logic                  advance;
   word_t                 entry_data;

   // Whole pipeline moves as one, or not at all
   assign advance  = link_enable & tx.ready;
   assign rx.ready = advance;

   // Flip bit 0 of the entering word, checksum left as sent
   assign entry_data = rx.data ^ word_t'(inject_error);

   always_ff @(posedge FCLK or negedge ARSTn) begin
      if (!ARSTn) begin
         valid_q <= '0;
      end else if (advance) begin
         valid_q[0] <= rx.valid;
         for (int i = 1; i < LANE_DELAY; i++) begin
            valid_q[i] <= valid_q[i-1];
         end
      end
   end

   always_ff @(posedge FCLK) begin
      if (advance) begin
         data_q[0]  <= entry_data;
         check_q[0] <= rx.check;
         for (int i = 1; i < LANE_DELAY; i++) begin
            data_q[i]  <= data_q[i-1];
            check_q[i] <= check_q[i-1];
         end
      end
   end

   assign tx.data  = data_q[LANE_DELAY-1];
   assign tx.check = check_q[LANE_DELAY-1];

   // Nothing comes out of a disabled link
   assign tx.valid = valid_q[LANE_DELAY-1] & link_enable;

   a_no_valid_when_down: assert property (
      @(posedge FCLK) disable iff (!ARSTn)
      !link_enable |-> !tx.valid
   ) else $error("lane_channel: output valid while link disabled");

endmodule

// File: verilog/lane_decoder.sv
/*
 * Lane decoder
 * Checksum verification, link training FSM and sticky error code
 */
`timescale 1ns/1ps

module lane_decoder #(
   parameter int ALIGN_WORDS = 8
) (
   input  logic                  FCLK,
   input  logic                  ARSTn,
   lane_if.receiver              rx,
   output link_pkg::word_t       rx_word,
   output logic                  rx_valid,
   output link_pkg::link_state_t link_state,
   output link_pkg::ecode_t      ecode
);
   import link_pkg::*;

   localparam int CNT_W = $clog2(ALIGN_WORDS + 1);

   typedef logic [CNT_W-1:0] cnt_t;

   cnt_t good_cnt;
   logic good;
   logic bad_word;

   // Receive side never stalls
   assign rx.ready = 1'b1;

   assign good     = (rx.check == calc_check(rx.data));
   assign bad_word = rx.valid & ~good;

   // Every word goes on, corrupt or not
   always_ff @(posedge FCLK or negedge ARSTn) begin
      if (!ARSTn) begin
         rx_valid <= 1'b0;
      end else begin
         rx_valid <= rx.valid;
      end
   end

   always_ff @(posedge FCLK) begin
      if (rx.valid) begin
         rx_word <= rx.data;
      end
   end

   // Training FSM, first word counts toward alignment
   always_ff @(posedge FCLK or negedge ARSTn) begin
      if (!ARSTn) begin
         link_state <= LINK_DOWN;
         good_cnt   <= '0;
      end else if (rx.valid) begin
         case (link_state)
            LINK_DOWN, LINK_TRAINING: begin
               if (!good) begin
                  link_state <= LINK_TRAINING;
                  good_cnt   <= '0;
               end else if (good_cnt == cnt_t'(ALIGN_WORDS - 1)) begin
                  link_state <= LINK_UP;
                  good_cnt   <= '0;
               end else begin
                  link_state <= LINK_TRAINING;
                  good_cnt   <= good_cnt + cnt_t'(1);
               end
            end
            LINK_UP: begin
               if (!good) begin
                  link_state <= LINK_TRAINING;
                  good_cnt   <= '0;
               end
            end
            default: begin
               link_state <= LINK_DOWN;
               good_cnt   <= '0;
            end
         endcase
      end
   end

   // Sticky until reset
   always_ff @(posedge FCLK or negedge ARSTn) begin
      if (!ARSTn) begin
         ecode <= ECODE_NONE;
      end else if (bad_word) begin
         ecode <= ECODE_CHECKSUM;
      end
   end

   a_down_after_bad: assert property (
      @(posedge FCLK) disable iff (!ARSTn)
      bad_word |=> link_state != LINK_UP
   ) else $error("lane_decoder: link up right after a bad word");

endmodule

// File: verilog/lane_encoder.sv
/*
 * Lane encoder
 * One-deep register stage that attaches the checksum byte to each word
 */
`timescale 1ns/1ps

module lane_encoder (
   input  logic            FCLK,
   input  logic            ARSTn,
   input  link_pkg::word_t word,
   input  logic            word_valid,
   output logic            word_ready,
   lane_if.sender          tx
);
   import link_pkg::*;

   logic load;

   // Take a new word when empty or when the current one leaves this cycle
   assign word_ready = ~tx.valid | tx.ready;
   assign load       = word_valid & word_ready;

   always_ff @(posedge FCLK or negedge ARSTn) begin
      if (!ARSTn) begin
         tx.valid <= 1'b0;
      end else if (load) begin
         tx.valid <= 1'b1;
      end else if (tx.ready) begin
         tx.valid <= 1'b0;
      end
   end

   // Payload and checksum
   always_ff @(posedge FCLK) begin
      if (load) begin
         tx.data  <= word;
         tx.check <= calc_check(word);
      end
   end

   // Stalled word must not change until it is taken
   a_stall_stable: assert property (
      @(posedge FCLK) disable iff (!ARSTn)
      tx.valid && !tx.ready |=> tx.valid && $stable(tx.data) && $stable(tx.check)
   ) else $error("lane_encoder: word changed while stalled");

endmodule

// File: verilog/lane_if.sv
/*
 * Lane word interface
 * One payload word with its checksum and a valid/ready handshake
 */
`timescale 1ns/1ps

interface lane_if;
   import link_pkg::*;

   word_t  data;
   check_t check;
   logic   valid;
   logic   ready;

   modport sender (
      output data,
      output check,
      output valid,
      input  ready
   );

   modport receiver (
      input  data,
      input  check,
      input  valid,
      output ready
   );

endinterface

// File: verilog/link_pkg.sv
/*
 * Link self-test shared definitions
 * Word and checksum types, link states, error codes and the checksum rule
 */
package link_pkg;

   typedef logic [63:0] word_t;
   typedef logic [7:0]  check_t;
   typedef logic [3:0]  ecode_t;

   typedef enum logic [1:0] {
      LINK_DOWN     = 2'd0,
      LINK_TRAINING = 2'd1,
      LINK_UP       = 2'd2
   } link_state_t;

   localparam ecode_t ECODE_NONE     = 4'h0;
   localparam ecode_t ECODE_CHECKSUM = 4'h1;

   // Status LEDs on the board
   localparam int LED_W = 3;

   // XOR of the eight bytes of a word
   function automatic check_t calc_check(input word_t w);
      check_t c;
      c = '0;
      for (int i = 0; i < 8; i++) begin
         c = c ^ w[i*8 +: 8];
      end
      return c;
   endfunction

endpackage

// File: verilog/link_test_top.sv
/*
 * Link self-test top level
 * Generator, encoder, channel, decoder and checker with status LEDs
 */
`timescale 1ns/1ps

module link_test_top #(
   parameter int LANE_DELAY  = 4,
   parameter int ALIGN_WORDS = 8
) (
   input  logic                       FCLK,
   input  logic                       ARSTn,
   input  logic                       link_enable,
   input  logic                       inject_error,
   output link_pkg::link_state_t      link_state,
   output link_pkg::ecode_t           ecode,
   output logic [link_pkg::LED_W-1:0] led
);
   import link_pkg::*;

   word_t word;
   logic  word_valid;
   logic  word_ready;
   word_t rx_word;
   logic  rx_valid;
   logic  data_error;

   lane_if enc_to_ch ();
   lane_if ch_to_dec ();

   pattern_gen i_gen (
      .FCLK      (FCLK),
      .ARSTn     (ARSTn),
      .word      (word),
      .word_valid(word_valid),
      .word_ready(word_ready)
   );

   lane_encoder i_enc (
      .FCLK      (FCLK),
      .ARSTn     (ARSTn),
      .word      (word),
      .word_valid(word_valid),
      .word_ready(word_ready),
      .tx        (enc_to_ch.sender)
   );

   lane_channel #(
      .LANE_DELAY(LANE_DELAY)
   ) i_channel (
      .FCLK        (FCLK),
      .ARSTn       (ARSTn),
      .link_enable (link_enable),
      .inject_error(inject_error),
      .rx          (enc_to_ch.receiver),
      .tx          (ch_to_dec.sender)
   );

   lane_decoder #(
      .ALIGN_WORDS(ALIGN_WORDS)
   ) i_dec (
      .FCLK      (FCLK),
      .ARSTn     (ARSTn),
      .rx        (ch_to_dec.receiver),
      .rx_word   (rx_word),
      .rx_valid  (rx_valid),
      .link_state(link_state),
      .ecode     (ecode)
   );

   traffic_checker i_chk (
      .FCLK      (FCLK),
      .ARSTn     (ARSTn),
      .rx_word   (rx_word),
      .rx_valid  (rx_valid),
      .data_error(data_error)
   );

   // Link up, no checksum error, data intact
   assign led[0] = (link_state == LINK_UP);
   assign led[1] = (ecode == ECODE_NONE);
   assign led[2] = ~data_error;

endmodule

// File: verilog/pattern_gen.sv
/*
 * Pattern generator
 * Incrementing 64-bit count, advanced on every accepted transfer
 */
`timescale 1ns/1ps

module pattern_gen (
   input  logic            FCLK,
   input  logic            ARSTn,
   output link_pkg::word_t word,
   output logic            word_valid,
   input  logic            word_ready
);

   logic accept;

   assign accept = word_valid & word_ready;

   // Source is always willing once out of reset
   always_ff @(posedge FCLK or negedge ARSTn) begin
      if (!ARSTn) begin
         word_valid <= 1'b0;
      end else begin
         word_valid <= 1'b1;
      end
   end

   // Count only moves when the word is taken
   always_ff @(posedge FCLK or negedge ARSTn) begin
      if (!ARSTn) begin
         word <= '0;
      end else if (accept) begin
         word <= word + 64'h1;
      end
   end

endmodule

// File: verilog/traffic_checker.sv
/*
 * Traffic checker
 * Compares received words with a local count, sticky mismatch flag
 */
`timescale 1ns/1ps

module traffic_checker (
   input  logic            FCLK,
   input  logic            ARSTn,
   input  link_pkg::word_t rx_word,
   input  logic            rx_valid,
   output logic            data_error
);
   import link_pkg::*;

   word_t ref_word;
   logic  mismatch;

   assign mismatch = rx_valid & (rx_word != ref_word);

   // Expected value of the next received word
   always_ff @(posedge FCLK or negedge ARSTn) begin
      if (!ARSTn) begin
         ref_word <= '0;
      end else if (rx_valid) begin
         ref_word <= ref_word + 64'h1;
      end
   end

   // Stays set once any word is wrong
   always_ff @(posedge FCLK or negedge ARSTn) begin
      if (!ARSTn) begin
         data_error <= 1'b0;
      end else if (mismatch) begin
         data_error <= 1'b1;
      end
   end

endmodule
